/* dv/mbox_tb.sv */
// directed testbench for the AXI4-Lite mailbox, drives mbox_top and checks it against a queue model
`default_nettype none

module mbox_tb;
    import mbox_pkg::*;

    localparam int DEPTH          = 8;    // default queue depth of dut0
    localparam int TIMEOUT_CYCLES = 2000; // the tests need roughly 600

    logic                   clk;
    logic                   rst;
    logic                   awvalid, awready, wvalid, wready;
    logic [AXIL_ADDR_W-1:0] awaddr, araddr;
    logic [AXIL_DATA_W-1:0] wdata, rdata;
    logic [3:0]             wstrb;
    logic                   bvalid, bready, arvalid, arready, rvalid, rready;
    logic [1:0]             bresp, rresp;

    logic [AXIL_DATA_W-1:0] model_q [$]; // expected queue contents, head first
    int                     seed      = 32'h0d9a_a637;
    int                     cycle_cnt = 0;

    mbox_top dut0 (
        .clk_i     ( clk     ), .rst_i     ( rst     ),
        .awvalid_i ( awvalid ), .awready_o ( awready ), .awaddr_i ( awaddr ),
        .wvalid_i  ( wvalid  ), .wready_o  ( wready  ), .wdata_i  ( wdata  ),
        .wstrb_i   ( wstrb   ),
        .bvalid_o  ( bvalid  ), .bready_i  ( bready  ), .bresp_o  ( bresp  ),
        .arvalid_i ( arvalid ), .arready_o ( arready ), .araddr_i ( araddr ),
        .rvalid_o  ( rvalid  ), .rready_i  ( rready  ), .rdata_o  ( rdata  ),
        .rresp_o   ( rresp   )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // period 100
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // status word as the register map defines it for n stored words
    function automatic logic [31:0] expected_status(input int n);
        logic [31:0] s;
        s                       = '0;
        s[STAT_FULL_BIT]        = (n == DEPTH);
        s[STAT_EMPTY_BIT]       = (n == 0);
        s[STAT_ALM_FULL_BIT]    = (n >= 6);
        s[STAT_ALM_EMPTY_BIT]   = (n <= 1);
        s[STAT_USAGE_LSB +: STAT_USAGE_W] = 8'(n % DEPTH); // count wraps to 0 when full
        return s;
    endfunction

    // one write, AW and W offered together; stall holds bready low that many cycles
    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                              input int stall, output logic [1:0] resp);
        bit aw_pend, w_pend, aw_fire, w_fire;
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        bready  = (stall == 0);
        while (aw_pend || w_pend) begin
            aw_fire = aw_pend && awready; // ready comes from registers, stable here
            w_fire  = w_pend && wready;
            @(posedge clk);
            #10;
            if (aw_fire) begin
                awvalid = 1'b0;
                aw_pend = 1'b0;
            end
            if (w_fire) begin
                wvalid  = 1'b0;
                w_pend  = 1'b0;
            end
        end
        while (!bvalid) begin
            @(posedge clk);
            #10;
        end
        resp = bresp;
        repeat (stall) begin          // response held, no new write may enter
            @(posedge clk);
            #10;
            check_eq("bvalid_o", 32'(bvalid), 32'd1);
            check_eq("bresp_o", 32'(bresp), 32'(resp));
            check_eq("awready_o", 32'(awready), 32'd0);
            check_eq("wready_o", 32'(wready), 32'd0);
        end
        bready = 1'b1;
        @(posedge clk);               // B handshake
        #10;
        bready = 1'b0;
    endtask

    // one read; stall holds rready low that many cycles once rvalid is up
    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, input int stall,
                             output logic [31:0] data, output logic [1:0] resp);
        bit ar_fire;
        arvalid = 1'b1;
        araddr  = addr;
        rready  = (stall == 0);
        ar_fire = 1'b0;
        while (!ar_fire) begin
            ar_fire = arready;
            @(posedge clk);
            #10;
        end
        arvalid = 1'b0;
        while (!rvalid) begin
            @(posedge clk);
            #10;
        end
        data = rdata;
        resp = rresp;
        repeat (stall) begin
            @(posedge clk);
            #10;
            check_eq("rvalid_o", 32'(rvalid), 32'd1);
            check_eq("rdata_o", rdata, data);
            check_eq("rresp_o", 32'(rresp), 32'(resp));
            check_eq("arready_o", 32'(arready), 32'd0);
        end
        rready = 1'b1;
        @(posedge clk);
        #10;
        rready = 1'b0;
    endtask

    task automatic push_word(input logic [31:0] d);
        logic [1:0] r;
        axil_write(REG_DATA, d, 0, r);
        if (model_q.size() < DEPTH) begin
            check_eq("bresp push", 32'(r), 32'(RESP_OKAY));
            model_q.push_back(d);
        end else begin
            check_eq("bresp push full", 32'(r), 32'(RESP_SLVERR)); // word dropped
        end
    endtask

    task automatic pop_word();
        logic [31:0] d;
        logic [1:0]  r;
        logic [31:0] exp;
        axil_read(REG_DATA, 0, d, r);
        if (model_q.size() == 0) begin
            check_eq("rresp pop empty", 32'(r), 32'(RESP_SLVERR));
            check_eq("rdata pop empty", d, 32'd0);
        end else begin
            exp = model_q.pop_front();
            check_eq("rresp pop", 32'(r), 32'(RESP_OKAY));
            check_eq("rdata pop", d, exp);
        end
    endtask

    task automatic verify_status();
        logic [31:0] d;
        logic [1:0]  r;
        axil_read(REG_STATUS, 0, d, r);
        check_eq("rresp status", 32'(r), 32'(RESP_OKAY));
        check_eq("status word", d, expected_status(model_q.size()));
    endtask

    task automatic reset_state();
        check_eq("awready_o", 32'(awready), 32'd1);
        check_eq("wready_o", 32'(wready), 32'd1);
        check_eq("arready_o", 32'(arready), 32'd1);
        check_eq("bvalid_o", 32'(bvalid), 32'd0);
        check_eq("rvalid_o", 32'(rvalid), 32'd0);
        verify_status();              // empty and almost empty, usage 0
        pop_word();                   // SLVERR on an empty queue
    endtask

    task automatic order_and_data();
        repeat (5) begin
            push_word($random(seed));
            verify_status();
        end
        repeat (5) begin
            pop_word();
            verify_status();
        end
    endtask

    task automatic thresholds_and_full();
        repeat (DEPTH) begin
            push_word($random(seed)); // alm_full at 6, alm_empty off above 1, full at 8
            verify_status();
        end
        push_word($random(seed));     // ninth word is refused
        verify_status();
        repeat (DEPTH) begin
            pop_word();
        end
        verify_status();
        pop_word();                   // exactly 8 were stored
    endtask

    task automatic flush_queue();
        logic [1:0] r;
        repeat (3) begin
            push_word($random(seed));
        end
        axil_write(REG_CTRL, 32'h1, 0, r);
        check_eq("bresp flush", 32'(r), 32'(RESP_OKAY));
        model_q.delete();
        verify_status();
        pop_word();
        push_word($random(seed));     // queue still usable afterwards
        pop_word();
        verify_status();
    endtask

    task automatic backpressure_and_decode();
        logic [31:0] d;
        logic [1:0]  r;
        logic [31:0] w;
        w = $random(seed);
        axil_write(REG_DATA, w, 4, r); // bready low for 4 cycles
        check_eq("bresp stalled", 32'(r), 32'(RESP_OKAY));
        model_q.push_back(w);
        verify_status();
        axil_read(REG_DATA, 3, d, r);  // rready low for 3 cycles
        check_eq("rresp stalled", 32'(r), 32'(RESP_OKAY));
        check_eq("rdata stalled", d, model_q.pop_front());
        axil_write(4'hc, 32'h5a5a_0001, 0, r);
        check_eq("bresp unmapped", 32'(r), 32'(RESP_SLVERR));
        axil_read(4'hc, 0, d, r);
        check_eq("rresp unmapped", 32'(r), 32'(RESP_SLVERR));
        check_eq("rdata unmapped", d, 32'd0);
        axil_read(REG_CTRL, 0, d, r);
        check_eq("rresp ctrl", 32'(r), 32'(RESP_OKAY));
        check_eq("rdata ctrl", d, 32'd0);
        push_word($random(seed));
        axil_write(REG_CTRL, 32'h0, 0, r);   // bit 0 clear, nothing flushed
        check_eq("bresp ctrl nop", 32'(r), 32'(RESP_OKAY));
        axil_write(REG_STATUS, 32'hffff_ffff, 0, r); // read-only, ignored
        check_eq("bresp status", 32'(r), 32'(RESP_OKAY));
        verify_status();
        pop_word();
    endtask

    initial begin
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;                // byte enables are ignored by the DUT
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        reset_state();
        order_and_data();
        thresholds_and_full();
        flush_queue();
        backpressure_and_decode();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the mailbox testbench with Verilator and run it, exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f verilog.f --top-module mbox_tb -Mdir obj_dir -o mbox_sim \
    && ./obj_dir/mbox_sim \
    || { echo "simulation build or run failed"; exit 1; }

/* src/axil_read_ch.sv */
// AXI4-Lite read path of the mailbox, pops the queue on data reads and returns the status word
`default_nettype none

module axil_read_ch #(
    parameter int unsigned  DEPTH      = 8,
    localparam int unsigned ADDR_DEPTH = $clog2(DEPTH)
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    // AR channel
    input  logic                             arvalid_i,
    output logic                             arready_o,
    input  logic [mbox_pkg::AXIL_ADDR_W-1:0] araddr_i,
    // R channel
    output logic                             rvalid_o,
    input  logic                             rready_i,
    output logic [mbox_pkg::AXIL_DATA_W-1:0] rdata_o,
    output logic [1:0]                       rresp_o,
    // queue side
    input  logic [mbox_pkg::AXIL_DATA_W-1:0] head_i,
    input  logic                             full_i,
    input  logic                             empty_i,
    input  logic                             alm_full_i,
    input  logic                             alm_empty_i,
    input  logic [ADDR_DEPTH-1:0]            usage_i,  // wrapped, 0 when full
    output logic                             pop_o     // one-cycle pulse
);
    import mbox_pkg::*;

    logic                   rvalid_q;
    logic [AXIL_DATA_W-1:0] rdata_q;
    logic [1:0]             rresp_q;
    logic                   ar_fire;
    logic [AXIL_DATA_W-1:0] status_word;
    logic [AXIL_DATA_W-1:0] rd_data;
    logic [1:0]             rd_resp;

    assign arready_o = !rvalid_q; // one read in flight at a time
    assign ar_fire   = arvalid_i && arready_o;
    // head is sampled in the same cycle, so it leaves the queue on this edge
    assign pop_o     = ar_fire && (araddr_i == REG_DATA) && !empty_i;

    // status layout, count zero-extended into the 8-bit field
    always_comb begin
        status_word                     = '0;
        status_word[STAT_FULL_BIT]      = full_i;
        status_word[STAT_EMPTY_BIT]     = empty_i;
        status_word[STAT_ALM_FULL_BIT]  = alm_full_i;
        status_word[STAT_ALM_EMPTY_BIT] = alm_empty_i;
        status_word[STAT_USAGE_LSB +: STAT_USAGE_W] = STAT_USAGE_W'(usage_i);
    end

    // read mux and response
    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (araddr_i)
            REG_DATA: begin
                if (empty_i) begin
                    rd_resp = RESP_SLVERR; // nothing to pop, data stays zero
                end else begin
                    rd_data = head_i;
                end
            end
            REG_STATUS: rd_data = status_word;
            REG_CTRL:   rd_data = '0;          // write-only strobe
            default:    rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else if (ar_fire) begin
            rvalid_q <= 1'b1;
        end else if (rready_i) begin
            rvalid_q <= 1'b0; // also covers the idle case
        end
    end

    // response payload, held while rready is low
    always_ff @(posedge clk_i) begin
        if (ar_fire) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    assign rresp_o  = rresp_q;

endmodule

`default_nettype wire

/* src/axil_write_ch.sv */
// AXI4-Lite write path of the mailbox, turns data and control writes into queue push and flush
`default_nettype none

module axil_write_ch (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    // AW channel
    input  logic                                 awvalid_i,
    output logic                                 awready_o,
    input  logic [mbox_pkg::AXIL_ADDR_W-1:0]     awaddr_i,
    // W channel
    input  logic                                 wvalid_i,
    output logic                                 wready_o,
    input  logic [mbox_pkg::AXIL_DATA_W-1:0]     wdata_i,
    input  logic [mbox_pkg::AXIL_DATA_W/8-1:0]   wstrb_i,   // no byte enables, always full word
    // B channel
    output logic                                 bvalid_o,
    input  logic                                 bready_i,
    output logic [1:0]                           bresp_o,
    // queue side
    input  logic                                 full_i,
    output logic                                 push_o,    // one-cycle pulse
    output logic                                 flush_o,   // one-cycle pulse
    output logic [mbox_pkg::AXIL_DATA_W-1:0]     push_data_o
);
    import mbox_pkg::*;

    logic                   aw_held_q;  // address captured, waiting for data
    logic [AXIL_ADDR_W-1:0] awaddr_q;
    logic                   w_held_q;   // data captured, waiting for address
    logic [AXIL_DATA_W-1:0] wdata_q;
    logic                   bvalid_q;
    logic [1:0]             bresp_q;
    logic                   do_wr;      // both halves in, act this cycle
    logic [1:0]             wr_resp;

    // each channel stalls while its item is held or a response is outstanding
    assign awready_o = !aw_held_q && !bvalid_q;
    assign wready_o  = !w_held_q && !bvalid_q;

    assign do_wr = aw_held_q && w_held_q; // true for exactly one cycle, the held bits clear next

    assign push_o      = do_wr && (awaddr_q == REG_DATA) && !full_i; // full means drop + error
    assign flush_o     = do_wr && (awaddr_q == REG_CTRL) && wdata_q[CTRL_FLUSH_BIT];
    assign push_data_o = wdata_q;

    assign bvalid_o = bvalid_q;
    assign bresp_o  = bresp_q;

    // response decode against the queue state of the action cycle
    always_comb begin
        wr_resp = RESP_OKAY;
        case (awaddr_q)
            REG_DATA: begin
                if (full_i) begin
                    wr_resp = RESP_SLVERR;
                end
            end
            REG_STATUS: wr_resp = RESP_OKAY; // read-only, write dropped silently
            REG_CTRL:   wr_resp = RESP_OKAY; // bit 0 clear is a no-op
            default:    wr_resp = RESP_SLVERR;
        endcase
    end

    // handshake state
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            if (awvalid_i && awready_o) begin
                aw_held_q <= 1'b1;
            end else if (do_wr) begin
                aw_held_q <= 1'b0;
            end
            if (wvalid_i && wready_o) begin
                w_held_q <= 1'b1;
            end else if (do_wr) begin
                w_held_q <= 1'b0;
            end
            if (do_wr) begin
                bvalid_q <= 1'b1;              // response the cycle after the action
            end else if (bvalid_q && bready_i) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // payload capture
    always_ff @(posedge clk_i) begin
        if (awvalid_i && awready_o) begin
            awaddr_q <= awaddr_i;
        end
        if (wvalid_i && wready_o) begin
            wdata_q <= wdata_i;
        end
        if (do_wr) begin
            bresp_q <= wr_resp; // stable while bready is low
        end
    end

endmodule

`default_nettype wire

/* src/fifo_v2.sv */
// mailbox queue with almost-full and almost-empty flags on top of fifo_v3, used by mbox_top
`default_nettype none

module fifo_v2 #(
    parameter bit           FALL_THROUGH = 1'b0,
    parameter int unsigned  DEPTH        = 8,    // power of two, 2 to 256
    parameter int unsigned  ALM_FULL_TH  = 6,    // alm_full_o once fill >= this
    parameter int unsigned  ALM_EMPTY_TH = 1,    // alm_empty_o while fill <= this
    localparam int unsigned ADDR_DEPTH   = $clog2(DEPTH)
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             flush_i,
    input  logic                             push_i,
    input  logic                             pop_i,
    input  logic [mbox_pkg::AXIL_DATA_W-1:0] data_i,
    output logic                             full_o,
    output logic                             empty_o,
    output logic                             alm_full_o,
    output logic                             alm_empty_o,
    output logic [ADDR_DEPTH-1:0]            usage_o,   // forwarded for the status register
    output logic [mbox_pkg::AXIL_DATA_W-1:0] data_o
);

    logic [ADDR_DEPTH:0] fill; // real count, usage_o alone reads 0 when full

    fifo_v3 #(
        .FALL_THROUGH ( FALL_THROUGH ),
        .DEPTH        ( DEPTH        )
    ) i_fifo_v3 (
        .clk_i   ( clk_i   ),
        .rst_i   ( rst_i   ),
        .flush_i ( flush_i ),
        .push_i  ( push_i  ),
        .pop_i   ( pop_i   ),
        .data_i  ( data_i  ),
        .full_o  ( full_o  ),
        .empty_o ( empty_o ),
        .usage_o ( usage_o ),
        .data_o  ( data_o  )
    );

    // full only happens at count DEPTH, a power of two, so full is the missing msb
    assign fill = {full_o, usage_o};

    // threshold compare on the wide count so a full queue stays almost full
    assign alm_full_o  = (fill >= (ADDR_DEPTH + 1)'(ALM_FULL_TH));
    assign alm_empty_o = (fill <= (ADDR_DEPTH + 1)'(ALM_EMPTY_TH));

endmodule

`default_nettype wire

/* src/fifo_v3.sv */
// circular-buffer word storage with fill count, instantiated by fifo_v2 in the mailbox queue
`default_nettype none

module fifo_v3 #(
    parameter bit           FALL_THROUGH = 1'b0, // empty queue hands data_i straight out
    parameter int unsigned  DEPTH        = 8,    // power of two, 2 to 256
    localparam int unsigned ADDR_DEPTH   = $clog2(DEPTH)
) (
    input  logic                             clk_i,
    input  logic                             rst_i,   // sync, active high
    input  logic                             flush_i, // drops all entries
    input  logic                             push_i,  // write data_i at the tail
    input  logic                             pop_i,   // drop the head
    input  logic [mbox_pkg::AXIL_DATA_W-1:0] data_i,
    output logic                             full_o,
    output logic                             empty_o,
    output logic [ADDR_DEPTH-1:0]            usage_o, // wraps to zero when full
    output logic [mbox_pkg::AXIL_DATA_W-1:0] data_o   // current head
);
    import mbox_pkg::*;

    logic [AXIL_DATA_W-1:0] mem_q [DEPTH];
    logic [ADDR_DEPTH-1:0]  rd_ptr_q, rd_ptr_n;
    logic [ADDR_DEPTH-1:0]  wr_ptr_q, wr_ptr_n;
    logic [ADDR_DEPTH:0]    cnt_q, cnt_n;   // extra bit tells full from empty
    logic                   bypass;         // fall-through word never touches storage
    logic                   do_push;
    logic                   do_pop;

    // next slot index, wraps at DEPTH
    function automatic logic [ADDR_DEPTH-1:0] ptr_inc(input logic [ADDR_DEPTH-1:0] ptr);
        if (ptr == ADDR_DEPTH'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (cnt_q == (ADDR_DEPTH + 1)'(DEPTH));
    // in fall-through mode a pushed word is visible in the same cycle
    assign empty_o = (cnt_q == '0) && !(FALL_THROUGH && push_i);
    assign usage_o = cnt_q[ADDR_DEPTH-1:0];

    assign bypass  = FALL_THROUGH && (cnt_q == '0) && push_i && pop_i;
    // a full queue still takes a word if a fall-through pop frees its slot
    assign do_push = push_i && (!full_o || (FALL_THROUGH && pop_i)) && !bypass;
    assign do_pop  = pop_i && !empty_o && !bypass; // pop on empty is ignored

    // head select
    always_comb begin
        data_o = mem_q[rd_ptr_q];
        if (FALL_THROUGH && (cnt_q == '0)) begin
            data_o = data_i; // nothing stored yet, show the incoming word
        end
    end

    // pointer and count update, push and pop together cancel in the count
    always_comb begin
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;
        if (do_push) begin
            wr_ptr_n = ptr_inc(wr_ptr_q);
            cnt_n    = cnt_n + 1'b1;
        end
        if (do_pop) begin
            rd_ptr_n = ptr_inc(rd_ptr_q);
            cnt_n    = cnt_n - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin // flush beats any push or pop this cycle
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    // storage array
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i; // tail slot, stale contents after flush are unreachable
        end
    end

endmodule

`default_nettype wire

/* src/mbox_pkg.sv */
// mailbox register map, AXI response codes and status word layout, imported by RTL and testbench
`default_nettype none

package mbox_pkg;

    // bus geometry
    localparam int unsigned AXIL_ADDR_W = 4;   // 16-byte register window
    localparam int unsigned AXIL_DATA_W = 32;  // also the queue word width

    // register offsets inside the window
    localparam logic [AXIL_ADDR_W-1:0] REG_DATA   = 4'h0; // write pushes, read pops
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 4'h4; // read-only flags and fill count
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 4'h8; // bit 0 flushes, reads as zero

    // control register fields
    localparam int unsigned CTRL_FLUSH_BIT = 0;

    // AXI response encodings in use
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10; // queue full/empty or unmapped offset

    // status word layout
    localparam int unsigned STAT_FULL_BIT      = 0;
    localparam int unsigned STAT_EMPTY_BIT     = 1;
    localparam int unsigned STAT_ALM_FULL_BIT  = 2;
    localparam int unsigned STAT_ALM_EMPTY_BIT = 3;
    // fill count field, bits 15:8
    localparam int unsigned STAT_USAGE_LSB     = 8;
    localparam int unsigned STAT_USAGE_W       = 8; // enough for DEPTH up to 256

    // bits 7:4 and 31:16 read as zero

endpackage

`default_nettype wire

/* src/mbox_top.sv */
// mailbox peripheral top, AXI4-Lite slave ports wired to the write and read handlers and the queue
`default_nettype none

module mbox_top #(
    parameter int unsigned DEPTH        = 8,    // power of two, 2 to 256
    parameter int unsigned ALM_FULL_TH  = 6,
    parameter int unsigned ALM_EMPTY_TH = 1,
    parameter bit          FALL_THROUGH = 1'b0
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    // write address
    input  logic                               awvalid_i,
    output logic                               awready_o,
    input  logic [mbox_pkg::AXIL_ADDR_W-1:0]   awaddr_i,
    // write data
    input  logic                               wvalid_i,
    output logic                               wready_o,
    input  logic [mbox_pkg::AXIL_DATA_W-1:0]   wdata_i,
    input  logic [mbox_pkg::AXIL_DATA_W/8-1:0] wstrb_i,
    // write response
    output logic                               bvalid_o,
    input  logic                               bready_i,
    output logic [1:0]                         bresp_o,
    // read address
    input  logic                               arvalid_i,
    output logic                               arready_o,
    input  logic [mbox_pkg::AXIL_ADDR_W-1:0]   araddr_i,
    // read data
    output logic                               rvalid_o,
    input  logic                               rready_i,
    output logic [mbox_pkg::AXIL_DATA_W-1:0]   rdata_o,
    output logic [1:0]                         rresp_o
);
    import mbox_pkg::*;

    localparam int unsigned USAGE_W = $clog2(DEPTH); // matches the queue's count width

    logic                   push;
    logic                   flush;
    logic                   pop;
    logic [AXIL_DATA_W-1:0] push_data;
    logic [AXIL_DATA_W-1:0] head;
    logic                   full;
    logic                   empty;
    logic                   alm_full;
    logic                   alm_empty;
    logic [USAGE_W-1:0]     usage;

    axil_write_ch i_write_ch (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .awvalid_i   ( awvalid_i ),
        .awready_o   ( awready_o ),
        .awaddr_i    ( awaddr_i  ),
        .wvalid_i    ( wvalid_i  ),
        .wready_o    ( wready_o  ),
        .wdata_i     ( wdata_i   ),
        .wstrb_i     ( wstrb_i   ),
        .bvalid_o    ( bvalid_o  ),
        .bready_i    ( bready_i  ),
        .bresp_o     ( bresp_o   ),
        .full_i      ( full      ),
        .push_o      ( push      ),
        .flush_o     ( flush     ),
        .push_data_o ( push_data )
    );

    axil_read_ch #(
        .DEPTH ( DEPTH )
    ) i_read_ch (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .arvalid_i   ( arvalid_i ),
        .arready_o   ( arready_o ),
        .araddr_i    ( araddr_i  ),
        .rvalid_o    ( rvalid_o  ),
        .rready_i    ( rready_i  ),
        .rdata_o     ( rdata_o   ),
        .rresp_o     ( rresp_o   ),
        .head_i      ( head      ),
        .full_i      ( full      ),
        .empty_i     ( empty     ),
        .alm_full_i  ( alm_full  ),
        .alm_empty_i ( alm_empty ),
        .usage_i     ( usage     ),
        .pop_o       ( pop       )
    );

    // both handlers share one fill state
    fifo_v2 #(
        .FALL_THROUGH ( FALL_THROUGH ),
        .DEPTH        ( DEPTH        ),
        .ALM_FULL_TH  ( ALM_FULL_TH  ),
        .ALM_EMPTY_TH ( ALM_EMPTY_TH )
    ) i_fifo (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .flush_i     ( flush     ),
        .push_i      ( push      ),
        .pop_i       ( pop       ),
        .data_i      ( push_data ),
        .full_o      ( full      ),
        .empty_o     ( empty     ),
        .alm_full_o  ( alm_full  ),
        .alm_empty_o ( alm_empty ),
        .usage_o     ( usage     ),
        .data_o      ( head      )
    );

endmodule

`default_nettype wire

/* verilog.f */
src/mbox_pkg.sv
src/fifo_v3.sv
src/fifo_v2.sv
src/axil_write_ch.sv
src/axil_read_ch.sv
src/mbox_top.sv
dv/mbox_tb.sv
